/* include/lc3b_macros.svh */
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// data and instruction word
`define LC3B_WORD_W 16

// register index width
`define LC3B_REG_W 3

// general purpose registers r0..r7
`define LC3B_NREGS 8

`endif

/* design/lc3b_types.sv */
`default_nettype none

`include "lc3b_macros.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp; // n, z, p

	typedef enum logic [3:0]
	{
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0]
	{
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		logic ld_reg;
		logic ld_cc;
		logic sr1_needed;
		logic sr2_needed;
		logic uses_cc;        // branch reads nzp
		logic regfilemux_sel; // 0 ir[11:9], 1 ir[2:0]
		logic destmux_sel;    // 0 ir[11:9], 1 r7
		logic branch_stall;
		logic mem_read;
		logic mem_write;
	} lc3b_control_word;

	typedef struct packed
	{
		logic valid;
		logic ld_reg;
		logic ld_cc;
		lc3b_reg drid;
	} lc3b_hazard_src;

	typedef struct packed
	{
		logic ex_br;
		logic ex_indirect;
		logic mem;
		logic mem_br;
		logic icache;
	} lc3b_stall_req;

	typedef struct packed
	{
		lc3b_word npc;
		lc3b_word ir;
		lc3b_control_word cw;
		lc3b_word sr1;
		lc3b_word sr2;
		lc3b_reg dr;
		lc3b_nzp cc;
		logic valid;
	} lc3b_decoded;

endpackage : lc3b_types

`default_nettype wire

/* design/control_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module control_rom
(
	input lc3b_types::lc3b_word ir,
	output lc3b_types::lc3b_control_word ctrl
);

lc3b_types::lc3b_opcode opcode;

assign opcode = lc3b_types::lc3b_opcode'(ir[15:12]);

always_comb
begin
	ctrl = '0;
	ctrl.opcode = opcode;
	ctrl.aluop = lc3b_types::alu_add; // address adds by default
	case (opcode)
		lc3b_types::op_br:
		begin
			ctrl.uses_cc = 1'b1;
			ctrl.branch_stall = 1'b1;
		end
		lc3b_types::op_add, lc3b_types::op_and:
		begin
			ctrl.aluop = (opcode == lc3b_types::op_and) ? lc3b_types::alu_and
				: lc3b_types::alu_add;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = ~ir[5]; // imm5 form has no sr2
			ctrl.regfilemux_sel = 1'b1;
		end
		lc3b_types::op_not:
		begin
			ctrl.aluop = lc3b_types::alu_not;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.sr1_needed = 1'b1;
		end
		lc3b_types::op_shf:
		begin
			if (!ir[4])
				ctrl.aluop = lc3b_types::alu_sll;
			else if (ir[5])
				ctrl.aluop = lc3b_types::alu_sra;
			else
				ctrl.aluop = lc3b_types::alu_srl;
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.sr1_needed = 1'b1;
		end
		lc3b_types::op_ldb, lc3b_types::op_ldr, lc3b_types::op_ldi:
		begin
			ctrl.ld_reg = 1'b1;
			ctrl.ld_cc = 1'b1;
			ctrl.sr1_needed = 1'b1; // base register
			ctrl.mem_read = 1'b1;
		end
		lc3b_types::op_stb, lc3b_types::op_str, lc3b_types::op_sti:
		begin
			ctrl.sr1_needed = 1'b1;
			ctrl.sr2_needed = 1'b1; // store source in ir[11:9]
			ctrl.mem_read = (opcode == lc3b_types::op_sti); // pointer fetch
			ctrl.mem_write = 1'b1;
		end
		lc3b_types::op_jsr:
		begin
			ctrl.aluop = lc3b_types::alu_pass;
			ctrl.ld_reg = 1'b1;
			ctrl.destmux_sel = 1'b1;
			ctrl.sr1_needed = ~ir[11]; // jsrr only
			ctrl.branch_stall = 1'b1;
		end
		lc3b_types::op_jmp:
		begin
			ctrl.aluop = lc3b_types::alu_pass;
			ctrl.sr1_needed = 1'b1;
			ctrl.branch_stall = 1'b1;
		end
		lc3b_types::op_lea:
		begin
			ctrl.ld_reg = 1'b1;
		end
		lc3b_types::op_trap:
		begin
			ctrl.aluop = lc3b_types::alu_pass;
			ctrl.ld_reg = 1'b1;
			ctrl.destmux_sel = 1'b1;
			ctrl.mem_read = 1'b1; // vector table
			ctrl.branch_stall = 1'b1;
		end
		default:
		begin
			ctrl.branch_stall = 1'b1; // rti
		end
	endcase
	if (ir == '0)
		ctrl = '0; // squashed nop
end

endmodule : control_rom

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module regfile
(
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_types::lc3b_reg dest,
	input lc3b_types::lc3b_word in,
	input lc3b_types::lc3b_reg src_a,
	input lc3b_types::lc3b_reg src_b,
	output lc3b_types::lc3b_word reg_a,
	output lc3b_types::lc3b_word reg_b
);

lc3b_types::lc3b_word data [`LC3B_NREGS];

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
	begin
		for (int i = 0; i < `LC3B_NREGS; i++)
			data[i] <= '0;
	end
	else if (load)
		data[dest] <= in;
end

assign reg_a = data[src_a]; // no write bypass
assign reg_b = data[src_b];

endmodule : regfile

`default_nettype wire

/* design/dep_check_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module dep_check_logic
(
	input logic valid,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	input lc3b_types::lc3b_control_word cw,
	input lc3b_types::lc3b_hazard_src ex_src,
	input lc3b_types::lc3b_hazard_src mem_src,
	input lc3b_types::lc3b_hazard_src wb_src,
	output logic dep_stall
);

// one later stage against the sources this instruction reads
function automatic logic stage_hit
(
	input lc3b_types::lc3b_hazard_src src,
	input lc3b_types::lc3b_control_word c,
	input lc3b_types::lc3b_reg s1,
	input lc3b_types::lc3b_reg s2
);
	logic reg_hit;
	logic cc_hit;
	reg_hit = src.ld_reg && ((c.sr1_needed && (src.drid == s1))
		|| (c.sr2_needed && (src.drid == s2)));
	cc_hit = src.ld_cc && c.uses_cc; // branch waits on nzp
	return src.valid && (reg_hit || cc_hit);
endfunction

logic ex_hit;
logic mem_hit;
logic wb_hit;

assign ex_hit = stage_hit(ex_src, cw, sr1, sr2);
assign mem_hit = stage_hit(mem_src, cw, sr1, sr2);
assign wb_hit = stage_hit(wb_src, cw, sr1, sr2);

assign dep_stall = valid && (ex_hit || mem_hit || wb_hit);

endmodule : dep_check_logic

`default_nettype wire

/* design/decode_stall_logic.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stall_logic
(
	input logic valid_in,
	input logic dep_stall,
	input lc3b_types::lc3b_stall_req stall_req,
	output logic valid,
	output logic load_ex
);

logic exec_busy;
logic mem_busy;
logic fetch_busy;

// group the downstream requests by stage
assign exec_busy = stall_req.ex_br || stall_req.ex_indirect;
assign mem_busy = stall_req.mem || stall_req.mem_br;
assign fetch_busy = stall_req.icache;

// any stall freezes id_ex
assign load_ex = ~(exec_busy || mem_busy || fetch_busy);

// a held instruction leaves a bubble behind it
assign valid = valid_in && !dep_stall;

endmodule : decode_stall_logic

`default_nettype wire

/* design/decode.sv */
`timescale 1ns/1ps
`default_nettype none

module decode
(
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_word ir_in,
	input logic valid_in,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	input lc3b_types::lc3b_word reg_data,
	input lc3b_types::lc3b_reg dest_reg,
	input lc3b_types::lc3b_nzp cc_data,
	input lc3b_types::lc3b_hazard_src ex_src,
	input lc3b_types::lc3b_hazard_src mem_src,
	input lc3b_types::lc3b_hazard_src wb_src,
	input lc3b_types::lc3b_stall_req stall_req,
	output lc3b_types::lc3b_decoded dec,
	output logic dep_stall,
	output logic decode_br_stall,
	output logic load_ex
);

lc3b_types::lc3b_control_word cw;
lc3b_types::lc3b_reg sr1_reg;
lc3b_types::lc3b_reg sr2_reg;
lc3b_types::lc3b_reg dr;
lc3b_types::lc3b_word sr1;
lc3b_types::lc3b_word sr2;
lc3b_types::lc3b_nzp cc;
logic valid;

control_rom control_store
(
	.ir(ir_in),
	.ctrl(cw)
);

assign sr1_reg = ir_in[8:6];
assign sr2_reg = cw.regfilemux_sel ? ir_in[2:0] : ir_in[11:9];
assign dr = cw.destmux_sel ? 3'd7 : ir_in[11:9]; // r7 link

regfile regfile_int
(
	.clk,
	.rst_n,
	.load(wb_ld_reg),
	.dest(dest_reg),
	.in(reg_data),
	.src_a(sr1_reg),
	.src_b(sr2_reg),
	.reg_a(sr1),
	.reg_b(sr2)
);

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		cc <= 3'b010; // z set
	else if (wb_ld_cc)
		cc <= cc_data;
end

assign decode_br_stall = valid_in && cw.branch_stall;

dep_check_logic dep_check
(
	.valid(valid_in),
	.sr1(sr1_reg),
	.sr2(sr2_reg),
	.cw,
	.ex_src,
	.mem_src,
	.wb_src,
	.dep_stall
);

decode_stall_logic stall_logic
(
	.valid_in,
	.dep_stall,
	.stall_req,
	.valid,
	.load_ex
);

always_comb
begin
	dec.npc = npc_in;
	dec.ir = ir_in;
	dec.cw = cw;
	dec.sr1 = sr1;
	dec.sr2 = sr2;
	dec.dr = dr;
	dec.cc = cc;
	dec.valid = valid;
end

endmodule : decode

`default_nettype wire

/* design/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
(
	input logic clk,
	input logic rst_n,
	input logic load,
	input lc3b_types::lc3b_decoded in,
	output lc3b_types::lc3b_decoded out
);

always_ff @(posedge clk or negedge rst_n)
begin
	if (!rst_n)
		out <= '0; // clears valid too
	else if (load)
		out <= in;
end

endmodule : id_ex_reg

`default_nettype wire

/* design/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit
(
	input logic clk,
	input logic rst_n,
	input lc3b_types::lc3b_word npc_in,
	input lc3b_types::lc3b_word ir_in,
	input logic valid_in,
	input logic wb_ld_reg,
	input logic wb_ld_cc,
	input lc3b_types::lc3b_word reg_data,
	input lc3b_types::lc3b_reg dest_reg,
	input lc3b_types::lc3b_nzp cc_data,
	input lc3b_types::lc3b_hazard_src ex_src,
	input lc3b_types::lc3b_hazard_src mem_src,
	input lc3b_types::lc3b_hazard_src wb_src,
	input lc3b_types::lc3b_stall_req stall_req,
	output lc3b_types::lc3b_decoded id_ex,
	output logic dep_stall,
	output logic decode_br_stall,
	output logic load_ex
);

lc3b_types::lc3b_decoded dec;

decode decode_stage
(
	.clk,
	.rst_n,
	.npc_in,
	.ir_in,
	.valid_in,
	.wb_ld_reg,
	.wb_ld_cc,
	.reg_data,
	.dest_reg,
	.cc_data,
	.ex_src,
	.mem_src,
	.wb_src,
	.stall_req,
	.dec,
	.dep_stall,
	.decode_br_stall,
	.load_ex
);

id_ex_reg id_ex_reg
(
	.clk,
	.rst_n,
	.load(load_ex),
	.in(dec),
	.out(id_ex)
);

endmodule : decode_unit

`default_nettype wire

/* tests/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

lc3b_types::lc3b_word shadow_regs [`LC3B_NREGS];
lc3b_types::lc3b_nzp shadow_cc;
lc3b_types::lc3b_decoded exp_id_ex;

task automatic model_reset();
	for (int i = 0; i < `LC3B_NREGS; i++)
		shadow_regs[i] = '0;
	shadow_cc = 3'b010; // z flag
	exp_id_ex = '0;
endtask

// ISA view of the control store field by field
function automatic lc3b_types::lc3b_control_word model_ctrl(input lc3b_types::lc3b_word ir);
	lc3b_types::lc3b_control_word c;
	lc3b_types::lc3b_opcode op;
	op = lc3b_types::lc3b_opcode'(ir[15:12]);
	c = '0;
	c.opcode = op;
	c.ld_reg = op inside {lc3b_types::op_add, lc3b_types::op_and, lc3b_types::op_not,
		lc3b_types::op_shf, lc3b_types::op_ldb, lc3b_types::op_ldr, lc3b_types::op_ldi,
		lc3b_types::op_jsr, lc3b_types::op_lea, lc3b_types::op_trap};
	c.ld_cc = op inside {lc3b_types::op_add, lc3b_types::op_and, lc3b_types::op_not,
		lc3b_types::op_shf, lc3b_types::op_ldb, lc3b_types::op_ldr, lc3b_types::op_ldi};
	c.sr1_needed = c.ld_cc || (op inside {lc3b_types::op_stb, lc3b_types::op_str,
		lc3b_types::op_sti, lc3b_types::op_jmp}) || (op == lc3b_types::op_jsr && !ir[11]);
	c.sr2_needed = (op inside {lc3b_types::op_stb, lc3b_types::op_str, lc3b_types::op_sti})
		|| (op inside {lc3b_types::op_add, lc3b_types::op_and} && !ir[5]);
	c.uses_cc = (op == lc3b_types::op_br);
	c.regfilemux_sel = op inside {lc3b_types::op_add, lc3b_types::op_and};
	c.destmux_sel = op inside {lc3b_types::op_jsr, lc3b_types::op_trap};
	c.branch_stall = op inside {lc3b_types::op_br, lc3b_types::op_jsr, lc3b_types::op_jmp,
		lc3b_types::op_trap, lc3b_types::op_rti};
	c.mem_read = op inside {lc3b_types::op_ldb, lc3b_types::op_ldr, lc3b_types::op_ldi,
		lc3b_types::op_sti, lc3b_types::op_trap};
	c.mem_write = op inside {lc3b_types::op_stb, lc3b_types::op_str, lc3b_types::op_sti};
	if (op == lc3b_types::op_and)
		c.aluop = lc3b_types::alu_and;
	else if (op == lc3b_types::op_not)
		c.aluop = lc3b_types::alu_not;
	else if (op == lc3b_types::op_shf)
		c.aluop = !ir[4] ? lc3b_types::alu_sll
			: (ir[5] ? lc3b_types::alu_sra : lc3b_types::alu_srl);
	else if (op inside {lc3b_types::op_jsr, lc3b_types::op_jmp, lc3b_types::op_trap})
		c.aluop = lc3b_types::alu_pass;
	else
		c.aluop = lc3b_types::alu_add;
	if (ir == 16'h0000)
		c = '0; // nop
	return c;
endfunction

function automatic logic model_dep_stall(input lc3b_types::lc3b_word ir, input logic valid,
	input lc3b_types::lc3b_hazard_src ex, input lc3b_types::lc3b_hazard_src mem,
	input lc3b_types::lc3b_hazard_src wb);
	lc3b_types::lc3b_control_word c;
	lc3b_types::lc3b_hazard_src stages [3];
	lc3b_types::lc3b_reg s1;
	lc3b_types::lc3b_reg s2;
	logic hit;
	c = model_ctrl(ir);
	stages[0] = ex;
	stages[1] = mem;
	stages[2] = wb;
	s1 = ir[8:6];
	s2 = c.regfilemux_sel ? ir[2:0] : ir[11:9];
	hit = 1'b0;
	foreach (stages[i])
	begin
		if (stages[i].valid && stages[i].ld_reg && c.sr1_needed && stages[i].drid == s1)
			hit = 1'b1;
		if (stages[i].valid && stages[i].ld_reg && c.sr2_needed && stages[i].drid == s2)
			hit = 1'b1;
		if (stages[i].valid && stages[i].ld_cc && c.uses_cc)
			hit = 1'b1; // branch on pending nzp
	end
	return valid && hit;
endfunction

function automatic lc3b_types::lc3b_decoded model_decode(input lc3b_types::lc3b_word npc,
	input lc3b_types::lc3b_word ir, input logic valid, input lc3b_types::lc3b_hazard_src ex,
	input lc3b_types::lc3b_hazard_src mem, input lc3b_types::lc3b_hazard_src wb);
	lc3b_types::lc3b_decoded d;
	d.npc = npc;
	d.ir = ir;
	d.cw = model_ctrl(ir);
	d.sr1 = shadow_regs[ir[8:6]];
	d.sr2 = shadow_regs[d.cw.regfilemux_sel ? ir[2:0] : ir[11:9]];
	d.dr = d.cw.destmux_sel ? 3'd7 : ir[11:9];
	d.cc = shadow_cc;
	d.valid = valid && !model_dep_stall(ir, valid, ex, mem, wb);
	return d;
endfunction

`endif

/* tests/decode_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_macros.svh"

module decode_tb;

localparam int reset_cycles = 16;
localparam int directed_cycles = 8 + 128 + 1;
localparam int rand_cycles = 2000;
localparam int test_cycles = reset_cycles + directed_cycles + rand_cycles;

logic clk;
logic rst_n;
lc3b_types::lc3b_word npc_in;
lc3b_types::lc3b_word ir_in;
logic valid_in;
logic wb_ld_reg;
logic wb_ld_cc;
lc3b_types::lc3b_word reg_data;
lc3b_types::lc3b_reg dest_reg;
lc3b_types::lc3b_nzp cc_data;
lc3b_types::lc3b_hazard_src ex_src;
lc3b_types::lc3b_hazard_src mem_src;
lc3b_types::lc3b_hazard_src wb_src;
lc3b_types::lc3b_stall_req stall_req;
lc3b_types::lc3b_decoded id_ex;
logic dep_stall;
logic decode_br_stall;
logic load_ex;

`include "decode_model.svh"

decode_unit decode_unit_i
(
	.clk,
	.rst_n,
	.npc_in,
	.ir_in,
	.valid_in,
	.wb_ld_reg,
	.wb_ld_cc,
	.reg_data,
	.dest_reg,
	.cc_data,
	.ex_src,
	.mem_src,
	.wb_src,
	.stall_req,
	.id_ex,
	.dep_stall,
	.decode_br_stall,
	.load_ex
);

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

task automatic fail_run();
	$display("Finished with errors");
	$fatal(1);
endtask

task automatic check_decoded(input string name, input lc3b_types::lc3b_decoded exp,
	input lc3b_types::lc3b_decoded act);
	if (exp !== act)
	begin
		$display("Mismatch %s: expected %h actual %h", name, exp, act);
		fail_run();
	end
endtask

task automatic check_ctrl(input string name, input lc3b_types::lc3b_control_word exp,
	input lc3b_types::lc3b_control_word act);
	if (exp !== act)
	begin
		$display("Mismatch %s: expected %h actual %h", name, exp, act);
		fail_run();
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act)
	begin
		$display("Mismatch %s: expected %h actual %h", name, exp, act);
		fail_run();
	end
endtask

function automatic lc3b_types::lc3b_hazard_src rand_hazard(input int valid_pct);
	lc3b_types::lc3b_hazard_src h;
	h = 6'($urandom);
	h.valid = ($urandom_range(0, 99) < valid_pct);
	return h;
endfunction

function automatic lc3b_types::lc3b_stall_req rand_stall();
	lc3b_types::lc3b_stall_req s;
	s = '0;
	if ($urandom_range(0, 99) < 15)
		s = 5'b00001 << $urandom_range(0, 4);
	return s;
endfunction

function automatic lc3b_types::lc3b_word rand_instr();
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_opcode op;
	op = lc3b_types::lc3b_opcode'($urandom_range(0, 15));
	ir = 16'($urandom);
	ir[15:12] = op;
	if ($urandom_range(0, 31) == 0)
		ir = '0; // occasional squashed nop
	return ir;
endfunction

// called 1 ns after a rising edge and returns 1 ns after the next one
task automatic run_cycle(input lc3b_types::lc3b_word ir, input logic valid,
	input lc3b_types::lc3b_hazard_src ex, input lc3b_types::lc3b_hazard_src mem,
	input lc3b_types::lc3b_hazard_src wb, input lc3b_types::lc3b_stall_req sr);
	lc3b_types::lc3b_decoded cur;
	lc3b_types::lc3b_control_word cw;
	logic exp_load;
	logic wr_reg;
	logic wr_cc;
	npc_in = 16'($urandom) & 16'hfffe;
	ir_in = ir;
	valid_in = valid;
	ex_src = ex;
	mem_src = mem;
	wb_src = wb;
	stall_req = sr;
	wr_reg = wb.valid && wb.ld_reg; // writeback enables follow wb_src
	wr_cc = wb.valid && wb.ld_cc;
	wb_ld_reg = wr_reg;
	wb_ld_cc = wr_cc;
	dest_reg = wb.drid;
	reg_data = 16'($urandom);
	cc_data = 3'b001 << $urandom_range(0, 2);
	#4;
	cw = model_ctrl(ir);
	cur = model_decode(npc_in, ir, valid, ex, mem, wb);
	exp_load = (sr == '0);
	check_bit("dep_stall", model_dep_stall(ir, valid, ex, mem, wb), dep_stall);
	check_bit("decode_br_stall", valid && cw.branch_stall, decode_br_stall);
	check_bit("load_ex", exp_load, load_ex);
	@(posedge clk);
	#1;
	if (exp_load)
		exp_id_ex = cur;
	if (wr_reg)
		shadow_regs[wb.drid] = reg_data;
	if (wr_cc)
		shadow_cc = cc_data;
	check_ctrl("id_ex.cw", exp_id_ex.cw, id_ex.cw);
	check_decoded("id_ex", exp_id_ex, id_ex);
endtask

initial
begin
	lc3b_types::lc3b_word ir;
	lc3b_types::lc3b_hazard_src idle;
	void'($urandom(48318));
	idle = '0;
	rst_n = 1'b0;
	npc_in = '0;
	ir_in = '0;
	valid_in = 1'b0;
	wb_ld_reg = 1'b0;
	wb_ld_cc = 1'b0;
	reg_data = '0;
	dest_reg = '0;
	cc_data = '0;
	ex_src = '0;
	mem_src = '0;
	wb_src = '0;
	stall_req = '0;
	model_reset();
	repeat (reset_cycles) @(posedge clk);
	#1;
	rst_n = 1'b1;
	check_decoded("id_ex after reset", '0, id_ex);
	// add rN, rN, rN reads back every reset register
	for (int r = 0; r < `LC3B_NREGS; r++)
		run_cycle({4'b0001, 3'(r), 3'(r), 3'b000, 3'(r)}, 1'b1, idle, idle, idle, '0);
	for (int op = 0; op < 16; op++)
	begin
		for (int mode = 0; mode < 8; mode++)
		begin
			ir = 16'($urandom);
			ir[15:12] = 4'(op);
			ir[11] = mode[2]; // jsr vs jsrr
			ir[5:4] = mode[1:0];
			run_cycle(ir, 1'b1, idle, idle, idle, '0);
		end
	end
	run_cycle(16'h0000, 1'b1, idle, idle, idle, '0);
	repeat (rand_cycles)
		run_cycle(rand_instr(), $urandom_range(0, 9) != 0, rand_hazard(15), rand_hazard(15),
			rand_hazard(25), rand_stall());
	$display("Finished with no errors");
	$finish;
end

initial
begin
	#(test_cycles * 20); // twice the nominal run length
	$display("Run timed out before all tests completed");
	fail_run();
end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
+incdir+tests
design/lc3b_types.sv
design/control_rom.sv
design/regfile.sv
design/dep_check_logic.sv
design/decode_stall_logic.sv
design/decode.sv
design/id_ex_reg.sv
design/decode_unit.sv
tests/decode_tb.sv
